//--- src.f
rtl/sh7034_pkg.sv
rtl/clk_prescaler.sv
rtl/wdt.sv
rtl/itu_channel.sv
rtl/ibus_read_mux.sv
rtl/sh7034_periph.sv
bench/tb_sh7034_periph.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_sh7034_periph \
	-f src.f -Mdir obj_dir -o tb_sim > sim.log 2>&1 &&
	./obj_dir/tb_sim >> sim.log 2>&1 ||
	{ echo "build or simulation error" >> sim.log; cat sim.log; exit 1; }
cat sim.log
! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log

//--- bench/tb_sh7034_periph.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sh7034_periph
	import sh7034_pkg::*;
();

	localparam logic [2:0] OP_WR    = 3'd0;
	localparam logic [2:0] OP_RD    = 3'd1;
	localparam logic [2:0] OP_WAIT  = 3'd2;
	localparam logic [2:0] OP_PIN   = 3'd3;
	localparam logic [2:0] OP_UNTIL = 3'd4;

	// Pin numbers carried in the address column
	localparam ibus_addr_t PIN_ITI    = 28'd0;
	localparam ibus_addr_t PIN_WDTOVF = 28'd1;
	localparam ibus_addr_t PIN_IMIA0  = 28'd2;
	localparam ibus_addr_t PIN_IMIA1  = 28'd3;
	localparam ibus_addr_t PIN_OVI0   = 28'd4;
	localparam ibus_addr_t PIN_OVI1   = 28'd5;
	localparam ibus_addr_t PIN_TIOCA0 = 28'd6;
	localparam ibus_addr_t PIN_TIOCA1 = 28'd7;

	// UNTIL steps keep {min, max} cycles in data and the level in exp
	typedef struct packed {
		logic [2:0] op;
		ibus_addr_t addr;
		ibus_data_t data;
		ibus_data_t exp;
	} step_t;

	logic       CLK;
	logic       RST_N;
	ibus_addr_t bus_a;
	ibus_data_t bus_di;
	logic       bus_we;
	logic       bus_req;
	ibus_data_t bus_do;
	logic       wdtovf_n;
	logic       iti_irq;
	logic [1:0] imia_irq;
	logic [1:0] ovi_irq;
	logic [1:0] tioca;

	step_t steps[$];
	int    data_errs;
	int    bit_errs;
	int    timing_errs;
	int    limit_cycles;

	sh7034_periph i_dut (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.bus_a    (bus_a),
		.bus_di   (bus_di),
		.bus_we   (bus_we),
		.bus_req  (bus_req),
		.bus_do   (bus_do),
		.wdtovf_n (wdtovf_n),
		.iti_irq  (iti_irq),
		.imia_irq (imia_irq),
		.ovi_irq  (ovi_irq),
		.tioca    (tioca)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic pin_level(input ibus_addr_t id);
		case (id)
			PIN_ITI:    return iti_irq;
			PIN_WDTOVF: return wdtovf_n;
			PIN_IMIA0:  return imia_irq[0];
			PIN_IMIA1:  return imia_irq[1];
			PIN_OVI0:   return ovi_irq[0];
			PIN_OVI1:   return ovi_irq[1];
			PIN_TIOCA0: return tioca[0];
			default:    return tioca[1];
		endcase
	endfunction

	function automatic string pin_label(input ibus_addr_t id);
		case (id)
			PIN_ITI:    return "iti_irq";
			PIN_WDTOVF: return "wdtovf_n";
			PIN_IMIA0:  return "imia_irq[0]";
			PIN_IMIA1:  return "imia_irq[1]";
			PIN_OVI0:   return "ovi_irq[0]";
			PIN_OVI1:   return "ovi_irq[1]";
			PIN_TIOCA0: return "tioca[0]";
			default:    return "tioca[1]";
		endcase
	endfunction

	function automatic ibus_data_t cycle_window(input int lo, input int hi);
		return {lo[15:0], hi[15:0]};
	endfunction

	task automatic check_data(input string name, input ibus_data_t got, input ibus_data_t exp);
		if (got !== exp) begin
			$display("error %s got 0x%h expected 0x%h", name, got, exp);
			data_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s got 0x%h expected 0x%h", name, got, exp);
			bit_errs++;
		end
	endtask

	task automatic add_step(input logic [2:0] op, input ibus_addr_t addr,
		input ibus_data_t data, input ibus_data_t exp);
		step_t s;
		s.op   = op;
		s.addr = addr;
		s.data = data;
		s.exp  = exp;
		steps.push_back(s);
	endtask

	task automatic build_table;
		timer_cnt_t gra0;
		timer_cnt_t gra1;
		timer_cnt_t gra_ovf;
		ibus_addr_t base;
		int         per0;
		int         per1;
		gra0    = timer_cnt_t'(8 + $urandom % 24);
		gra1    = gra0 + timer_cnt_t'(1 + $urandom % 16);
		gra_ovf = timer_cnt_t'(32'h0100 + $urandom % 32'hFE00);
		per0    = int'(gra0) + 1;
		per1    = int'(gra1) + 1;

		// Reset values of every register, pin and an unmapped hole
		add_step(OP_RD, WTCSR_ADDR, 0, 32'h0);
		add_step(OP_RD, WTCNT_ADDR, 0, 32'h0);
		for (int ch = 0; ch < 2; ch++) begin
			base = (ch == 0) ? ITU0_BASE : ITU1_BASE;
			add_step(OP_RD, base + ITU_TCR_OFS, 0, 32'h0);
			add_step(OP_RD, base + ITU_TIER_OFS, 0, 32'h0);
			add_step(OP_RD, base + ITU_TSR_OFS, 0, 32'h0);
			add_step(OP_RD, base + ITU_TCNT_OFS, 0, 32'h0);
			add_step(OP_RD, base + ITU_GRA_OFS, 0, 32'h0000FFFF);
		end
		add_step(OP_RD, 28'h5FFFF00, 0, 32'h0);
		add_step(OP_RD, ITU0_BASE + 28'd3, 0, 32'h0);
		for (int id = 0; id < 8; id++) begin
			add_step(OP_PIN, ibus_addr_t'(id), 0,
				ibus_data_t'(ibus_addr_t'(id) == PIN_WDTOVF));
		end

		// Watchdog write keys
		add_step(OP_WR, WTCSR_ADDR, {16'h0, 8'h3C, 8'h77}, 0);
		add_step(OP_RD, WTCNT_ADDR, 0, 32'h0);
		add_step(OP_WR, WTCSR_ADDR, {16'h0, WDT_KEY_CNT, 8'h33}, 0);
		add_step(OP_RD, WTCNT_ADDR, 0, 32'h33);
		add_step(OP_WR, WTCSR_ADDR, {16'h0, WDT_KEY_CSR, 8'h07}, 0);
		add_step(OP_RD, WTCSR_ADDR, 0, 32'h07);
		add_step(OP_WR, WTCSR_ADDR, {16'h0, 8'hA4, 8'h60}, 0);
		add_step(OP_RD, WTCSR_ADDR, 0, 32'h07);
		add_step(OP_WR, WTCSR_ADDR, {16'h0, WDT_KEY_CSR, 8'h00}, 0);
		add_step(OP_RD, WTCSR_ADDR, 0, 32'h0);

		// CCLR with tick select 0 gives a compare period of GRA+1
		add_step(OP_WR, ITU1_BASE + ITU_GRA_OFS, {16'h0, gra1}, 0);
		add_step(OP_WR, ITU1_BASE + ITU_TIER_OFS, 32'h01, 0);
		add_step(OP_WR, ITU0_BASE + ITU_GRA_OFS, {16'h0, gra0}, 0);
		add_step(OP_WR, ITU0_BASE + ITU_TIER_OFS, 32'h01, 0);
		add_step(OP_WR, ITU0_BASE + ITU_TCR_OFS, 32'h60, 0);
		add_step(OP_UNTIL, PIN_TIOCA0, cycle_window(per0, per0), 32'h1);
		add_step(OP_PIN, PIN_IMIA0, 0, 32'h1);
		add_step(OP_UNTIL, PIN_TIOCA0, cycle_window(per0, per0), 32'h0);
		add_step(OP_WR, ITU1_BASE + ITU_TCR_OFS, 32'h60, 0);
		add_step(OP_UNTIL, PIN_TIOCA1, cycle_window(per1, per1), 32'h1);
		add_step(OP_PIN, PIN_IMIA1, 0, 32'h1);
		add_step(OP_UNTIL, PIN_TIOCA1, cycle_window(per1, per1), 32'h0);
		add_step(OP_WR, ITU0_BASE + ITU_TCR_OFS, 32'h20, 0);
		add_step(OP_WR, ITU1_BASE + ITU_TCR_OFS, 32'h20, 0);
		add_step(OP_WR, ITU0_BASE + ITU_TSR_OFS, 32'h0, 0);
		add_step(OP_WR, ITU1_BASE + ITU_TSR_OFS, 32'h0, 0);
		add_step(OP_PIN, PIN_IMIA0, 0, 32'h0);
		add_step(OP_PIN, PIN_IMIA1, 0, 32'h0);
		add_step(OP_RD, ITU0_BASE + ITU_TSR_OFS, 0, 32'h0);
		add_step(OP_RD, ITU0_BASE + ITU_TCR_OFS, 0, 32'h20);
		add_step(OP_RD, ITU0_BASE + ITU_TIER_OFS, 0, 32'h01);

		// Overflow 16 ticks after start without CCLR
		add_step(OP_WR, ITU1_BASE + ITU_TCR_OFS, 32'h00, 0);
		add_step(OP_WR, ITU1_BASE + ITU_TIER_OFS, 32'h04, 0);
		add_step(OP_WR, ITU1_BASE + ITU_GRA_OFS, {16'h0, gra_ovf}, 0);
		add_step(OP_WR, ITU1_BASE + ITU_TCNT_OFS, 32'h0000FFF0, 0);
		add_step(OP_PIN, PIN_OVI1, 0, 32'h0);
		add_step(OP_WR, ITU1_BASE + ITU_TCR_OFS, 32'h40, 0);
		add_step(OP_UNTIL, PIN_OVI1, cycle_window(16, 16), 32'h1);
		add_step(OP_RD, ITU1_BASE + ITU_TCNT_OFS, 0, 32'h0);
		add_step(OP_RD, ITU1_BASE + ITU_TSR_OFS, 0, 32'h04);
		add_step(OP_RD, ITU1_BASE + ITU_TCR_OFS, 0, 32'h40);
		add_step(OP_RD, ITU1_BASE + ITU_TIER_OFS, 0, 32'h04);
		add_step(OP_WR, ITU1_BASE + ITU_TCR_OFS, 32'h00, 0);

		// Interval mode runs 16 ticks of divide by 2
		add_step(OP_WR, WTCSR_ADDR, {16'h0, WDT_KEY_CNT, 8'hF0}, 0);
		add_step(OP_WR, WTCSR_ADDR, {16'h0, WDT_KEY_CSR, 8'h20}, 0);
		add_step(OP_UNTIL, PIN_ITI, cycle_window(30, 34), 32'h1);
		add_step(OP_RD, WTCSR_ADDR, 0, 32'hA0);
		add_step(OP_PIN, PIN_WDTOVF, 0, 32'h1);
		add_step(OP_WR, WTCSR_ADDR, {16'h0, WDT_KEY_CSR, 8'h00}, 0);
		add_step(OP_PIN, PIN_ITI, 0, 32'h0);

		// Watchdog mode
		add_step(OP_WR, WTCSR_ADDR, {16'h0, WDT_KEY_CNT, 8'hF0}, 0);
		add_step(OP_WR, WTCSR_ADDR, {16'h0, WDT_KEY_CSR, 8'h60}, 0);
		add_step(OP_UNTIL, PIN_WDTOVF, cycle_window(30, 34), 32'h0);
		add_step(OP_PIN, PIN_ITI, 0, 32'h0);
		add_step(OP_UNTIL, PIN_WDTOVF,
			cycle_window(WDT_OVF_PULSE_DEF, WDT_OVF_PULSE_DEF), 32'h1);
		add_step(OP_PIN, PIN_ITI, 0, 32'h0);
		add_step(OP_WR, WTCSR_ADDR, {16'h0, WDT_KEY_CSR, 8'h40}, 0);
		add_step(OP_RD, WTCSR_ADDR, 0, 32'h40);
		add_step(OP_WAIT, 0, 32'd4, 0);
	endtask

	task automatic apply_step(input step_t s);
		int count;
		int lo;
		int hi;
		count = 0;
		lo    = int'(s.data[31:16]);
		hi    = int'(s.data[15:0]);
		case (s.op)
			OP_WR, OP_RD: begin
				bus_a   = s.addr;
				bus_di  = s.data;
				bus_we  = (s.op == OP_WR);
				bus_req = 1'b1;
				@(posedge CLK);
				#1;
				bus_req = 1'b0;
				bus_we  = 1'b0;
				if (s.op == OP_RD) begin
					check_data($sformatf("bus_do (read 0x%h)", s.addr), bus_do, s.exp);
				end
			end
			OP_WAIT: begin
				repeat (s.data) @(posedge CLK);
				#1;
			end
			OP_PIN: check_bit(pin_label(s.addr), pin_level(s.addr), s.exp[0]);
			default: begin
				while (pin_level(s.addr) !== s.exp[0] && count < hi) begin
					@(posedge CLK);
					#1;
					count++;
				end
				if (pin_level(s.addr) !== s.exp[0]) begin
					$display("%s did not reach %0b within %0d cycles",
						pin_label(s.addr), s.exp[0], hi);
					timing_errs++;
				end else if (count < lo) begin
					$display("%s reached %0b after %0d cycles, expected %0d to %0d",
						pin_label(s.addr), s.exp[0], count, lo, hi);
					timing_errs++;
				end
			end
		endcase
	endtask

	initial begin
		int budget;
		RST_N       = 1'b0;
		bus_a       = '0;
		bus_di      = '0;
		bus_we      = 1'b0;
		bus_req     = 1'b0;
		data_errs   = 0;
		bit_errs    = 0;
		timing_errs = 0;
		void'($urandom(14));
		build_table();

		// Run bound from table length and every wait it may take
		budget = steps.size() + 4;
		foreach (steps[i]) begin
			if (steps[i].op == OP_WAIT) begin
				budget += int'(steps[i].data);
			end else if (steps[i].op == OP_UNTIL) begin
				budget += int'(steps[i].data[15:0]);
			end
		end
		limit_cycles = budget * 2;

		repeat (4) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		foreach (steps[i]) begin
			apply_step(steps[i]);
		end

		$display("errors: data %0d, pin %0d, timing %0d", data_errs, bit_errs, timing_errs);
		if (data_errs == 0 && bit_errs == 0 && timing_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge CLK);
		$display("run did not complete within %0d cycles", limit_cycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/sh7034_periph.sv
`timescale 1ns/1ps
`default_nettype none

module sh7034_periph
	import sh7034_pkg::*;
#(
	parameter int         WDT_OVF_PULSE = WDT_OVF_PULSE_DEF,
	parameter ibus_addr_t ITU0_ADDR     = ITU0_BASE,
	parameter ibus_addr_t ITU1_ADDR     = ITU1_BASE
)
(
	input  logic       CLK,
	input  logic       RST_N,

	input  ibus_addr_t bus_a,
	input  ibus_data_t bus_di,
	input  logic       bus_we,
	input  logic       bus_req,
	output ibus_data_t bus_do,

	output logic       wdtovf_n,
	output logic       iti_irq,
	output logic [1:0] imia_irq,
	output logic [1:0] ovi_irq,
	output logic [1:0] tioca
);

	presc_ce_t  presc_ce;
	logic       wdt_hit;
	logic       itu0_hit;
	logic       itu1_hit;
	ibus_data_t wdt_data;
	ibus_data_t itu0_data;
	ibus_data_t itu1_data;

	clk_prescaler i_presc (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.presc_ce (presc_ce)
	);

	wdt #(.OVF_PULSE(WDT_OVF_PULSE)) i_wdt (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.presc_ce (presc_ce),
		.bus_a    (bus_a),
		.bus_di   (bus_di),
		.bus_we   (bus_we),
		.bus_req  (bus_req),
		.rd_hit   (wdt_hit),
		.rd_data  (wdt_data),
		.iti_irq  (iti_irq),
		.wdtovf_n (wdtovf_n)
	);

	itu_channel #(.CH_BASE(ITU0_ADDR)) i_itu0 (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.presc_ce (presc_ce),
		.bus_a    (bus_a),
		.bus_di   (bus_di),
		.bus_we   (bus_we),
		.bus_req  (bus_req),
		.rd_hit   (itu0_hit),
		.rd_data  (itu0_data),
		.imia_irq (imia_irq[0]),
		.ovi_irq  (ovi_irq[0]),
		.tioca    (tioca[0])
	);

	itu_channel #(.CH_BASE(ITU1_ADDR)) i_itu1 (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.presc_ce (presc_ce),
		.bus_a    (bus_a),
		.bus_di   (bus_di),
		.bus_we   (bus_we),
		.bus_req  (bus_req),
		.rd_hit   (itu1_hit),
		.rd_data  (itu1_data),
		.imia_irq (imia_irq[1]),
		.ovi_irq  (ovi_irq[1]),
		.tioca    (tioca[1])
	);

	ibus_read_mux i_rd_mux (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.bus_req   (bus_req),
		.bus_we    (bus_we),
		.wdt_hit   (wdt_hit),
		.itu0_hit  (itu0_hit),
		.itu1_hit  (itu1_hit),
		.wdt_data  (wdt_data),
		.itu0_data (itu0_data),
		.itu1_data (itu1_data),
		.bus_do    (bus_do)
	);

endmodule

`default_nettype wire

//--- rtl/ibus_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module ibus_read_mux
	import sh7034_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       bus_req,
	input  logic       bus_we,

	input  logic       wdt_hit,
	input  logic       itu0_hit,
	input  logic       itu1_hit,
	input  ibus_data_t wdt_data,
	input  ibus_data_t itu0_data,
	input  ibus_data_t itu1_data,

	output ibus_data_t bus_do
);

	ibus_data_t rd_sel;

	// Unmapped reads fall through to zero
	assign rd_sel = ({IBUS_DATA_W{wdt_hit}} & wdt_data) |
		({IBUS_DATA_W{itu0_hit}} & itu0_data) |
		({IBUS_DATA_W{itu1_hit}} & itu1_data);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			bus_do <= '0;
		end else if (bus_req && !bus_we) begin
			bus_do <= rd_sel;
		end
	end

	// Peripheral address ranges must not overlap
	a_hit_onehot: assert property (@(posedge CLK) disable iff (!RST_N)
		$onehot0({wdt_hit, itu0_hit, itu1_hit}));

endmodule

`default_nettype wire

//--- rtl/itu_channel.sv
`timescale 1ns/1ps
`default_nettype none

module itu_channel
	import sh7034_pkg::*;
#(
	parameter ibus_addr_t CH_BASE = ITU0_BASE
)
(
	input  logic       CLK,
	input  logic       RST_N,

	input  presc_ce_t  presc_ce,

	input  ibus_addr_t bus_a,
	input  ibus_data_t bus_di,
	input  logic       bus_we,
	input  logic       bus_req,
	output logic       rd_hit,
	output ibus_data_t rd_data,

	output logic       imia_irq,
	output logic       ovi_irq,
	output logic       tioca
);

	logic [1:0] tpsc;
	logic       cclr;
	logic       str;
	logic       imiae;
	logic       ovie;
	logic       imfa;
	logic       ovf;
	timer_cnt_t tcnt;
	timer_cnt_t gra;
	logic       sel_tcr;
	logic       sel_tier;
	logic       sel_tsr;
	logic       sel_tcnt;
	logic       sel_gra;
	logic       wr;
	logic       tpsc_ce;
	logic       tick;
	logic       cmp;
	logic       wrap;

	assign sel_tcr  = bus_a == CH_BASE + ITU_TCR_OFS;
	assign sel_tier = bus_a == CH_BASE + ITU_TIER_OFS;
	assign sel_tsr  = bus_a == CH_BASE + ITU_TSR_OFS;
	assign sel_tcnt = bus_a == CH_BASE + ITU_TCNT_OFS;
	assign sel_gra  = bus_a == CH_BASE + ITU_GRA_OFS;
	assign wr       = bus_req && bus_we;

	always_comb begin
		case (tpsc)
			2'd0:    tpsc_ce = 1'b1;
			2'd1:    tpsc_ce = presc_ce[0];
			2'd2:    tpsc_ce = presc_ce[1];
			default: tpsc_ce = presc_ce[2];
		endcase
	end

	assign tick = str && tpsc_ce;
	assign cmp  = tick && tcnt == gra;
	assign wrap = tick && tcnt == 16'hFFFF;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tpsc  <= 2'd0;
			cclr  <= 1'b0;
			str   <= 1'b0;
			imiae <= 1'b0;
			ovie  <= 1'b0;
			imfa  <= 1'b0;
			ovf   <= 1'b0;
			tcnt  <= '0;
			gra   <= 16'hFFFF;
			tioca <= 1'b0;
		end else begin
			if (wr && sel_tcr) begin
				tpsc <= bus_di[1:0];
				cclr <= bus_di[5];
				str  <= bus_di[6];
			end
			if (wr && sel_tier) begin
				imiae <= bus_di[0];
				ovie  <= bus_di[2];
			end
			if (wr && sel_gra) begin
				gra <= bus_di[15:0];
			end

			// Writing 0 clears a flag but a new event wins
			imfa <= cmp || ((wr && sel_tsr) ? (imfa && bus_di[0]) : imfa);
			ovf  <= wrap || ((wr && sel_tsr) ? (ovf && bus_di[2]) : ovf);

			if (wr && sel_tcnt) begin
				tcnt <= bus_di[15:0];
			end else if (cmp && cclr) begin
				tcnt <= '0;
			end else if (tick) begin
				tcnt <= tcnt + 16'd1;
			end

			if (cmp) begin
				tioca <= !tioca;
			end
		end
	end

	assign imia_irq = imfa && imiae;
	assign ovi_irq  = ovf && ovie;

	assign rd_hit = bus_req && !bus_we && (sel_tcr || sel_tier || sel_tsr || sel_tcnt || sel_gra);

	always_comb begin
		rd_data = '0;
		if (sel_tcr) begin
			rd_data[7:0] = {1'b0, str, cclr, 3'b000, tpsc};
		end else if (sel_tier) begin
			rd_data[7:0] = {5'b00000, ovie, 1'b0, imiae};
		end else if (sel_tsr) begin
			rd_data[7:0] = {5'b00000, ovf, 1'b0, imfa};
		end else if (sel_tcnt) begin
			rd_data[15:0] = tcnt;
		end else if (sel_gra) begin
			rd_data[15:0] = gra;
		end
	end

	// Output only toggles on an edge that sets the compare flag
	a_tioca_on_cmp: assert property (@(posedge CLK) disable iff (!RST_N)
		$changed(tioca) |-> imfa);

endmodule

`default_nettype wire

//--- rtl/wdt.sv
`timescale 1ns/1ps
`default_nettype none

module wdt
	import sh7034_pkg::*;
#(
	parameter int OVF_PULSE = WDT_OVF_PULSE_DEF
)
(
	input  logic       CLK,
	input  logic       RST_N,

	input  presc_ce_t  presc_ce,

	input  ibus_addr_t bus_a,
	input  ibus_data_t bus_di,
	input  logic       bus_we,
	input  logic       bus_req,
	output logic       rd_hit,
	output ibus_data_t rd_data,

	output logic       iti_irq,
	output logic       wdtovf_n
);

	localparam int PULSE_W = $clog2(OVF_PULSE + 1);

	logic               ovf;
	logic               wt_it;
	logic               tme;
	logic [2:0]         cks;
	wdt_cnt_t           wtcnt;
	logic [PULSE_W-1:0] pulse_cnt;
	logic               csr_wr;
	logic               cnt_wr;
	logic               cks_ce;
	logic               tick;
	logic               wrap;

	// Key in the upper byte of the low half word, value in the low byte
	assign csr_wr = bus_req && bus_we && bus_a == WTCSR_ADDR && bus_di[15:8] == WDT_KEY_CSR;
	assign cnt_wr = bus_req && bus_we && bus_a == WTCSR_ADDR && bus_di[15:8] == WDT_KEY_CNT;

	always_comb begin
		case (cks)
			3'd0:    cks_ce = presc_ce[0];
			3'd1:    cks_ce = presc_ce[5];
			3'd2:    cks_ce = presc_ce[6];
			3'd3:    cks_ce = presc_ce[7];
			3'd4:    cks_ce = presc_ce[8];
			3'd5:    cks_ce = presc_ce[9];
			3'd6:    cks_ce = presc_ce[11];
			default: cks_ce = presc_ce[12];
		endcase
	end

	assign tick = tme && cks_ce;
	assign wrap = tick && wtcnt == 8'hFF;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ovf       <= 1'b0;
			wt_it     <= 1'b0;
			tme       <= 1'b0;
			cks       <= 3'd0;
			wtcnt     <= '0;
			pulse_cnt <= '0;
		end else begin
			if (csr_wr) begin
				wt_it <= bus_di[6];
				tme   <= bus_di[5];
				cks   <= bus_di[2:0];
			end
			// OVF is clear-only from the bus
			ovf <= wrap || (csr_wr ? (ovf && bus_di[7]) : ovf);

			if (cnt_wr) begin
				wtcnt <= bus_di[7:0];
			end else if (tick) begin
				wtcnt <= wtcnt + 8'd1;
			end

			// No retrigger while a pulse is running
			if (wrap && wt_it && pulse_cnt == '0) begin
				pulse_cnt <= PULSE_W'(OVF_PULSE);
			end else if (pulse_cnt != '0) begin
				pulse_cnt <= pulse_cnt - PULSE_W'(1);
			end
		end
	end

	assign iti_irq  = ovf && !wt_it;
	assign wdtovf_n = pulse_cnt == '0;

	assign rd_hit  = bus_req && !bus_we && (bus_a == WTCSR_ADDR || bus_a == WTCNT_ADDR);
	assign rd_data = (bus_a == WTCNT_ADDR) ? ibus_data_t'(wtcnt) :
		ibus_data_t'({ovf, wt_it, tme, 2'b00, cks});

	// Overflow pulse returns high exactly OVF_PULSE cycles after it falls
	a_ovf_pulse_len: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(wdtovf_n) |-> ##OVF_PULSE wdtovf_n);

endmodule

`default_nettype wire

//--- rtl/clk_prescaler.sv
`timescale 1ns/1ps
`default_nettype none

module clk_prescaler
	import sh7034_pkg::*;
(
	input  logic      CLK,
	input  logic      RST_N,

	output presc_ce_t presc_ce
);

	logic [PRESC_W-1:0] div_cnt;
	logic [PRESC_W-1:0] tap;

	// Tap i fires when the low i+1 counter bits are all ones
	for (genvar i = 0; i < PRESC_W; i++) begin : g_tap
		assign tap[i] = &div_cnt[i:0];
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt  <= '0;
			presc_ce <= '0;
		end else begin
			div_cnt  <= div_cnt + PRESC_W'(1);
			presc_ce <= tap;
		end
	end

endmodule

`default_nettype wire

//--- rtl/sh7034_pkg.sv
`default_nettype none

package sh7034_pkg;

	// Internal peripheral bus
	localparam int IBUS_ADDR_W = 28;
	localparam int IBUS_DATA_W = 32;

	typedef logic [IBUS_ADDR_W-1:0] ibus_addr_t;
	typedef logic [IBUS_DATA_W-1:0] ibus_data_t;

	// Bit i of the prescaler vector pulses every 2**(i+1) cycles
	localparam int PRESC_W = 13;

	typedef logic [PRESC_W-1:0] presc_ce_t;

	typedef logic [7:0]  wdt_cnt_t;
	typedef logic [15:0] timer_cnt_t;

	// Both watchdog registers are written through WTCSR_ADDR
	localparam ibus_addr_t WTCSR_ADDR = 28'h5FFFFB8;
	localparam ibus_addr_t WTCNT_ADDR = 28'h5FFFFB9;

	localparam logic [7:0] WDT_KEY_CSR = 8'hA5;
	localparam logic [7:0] WDT_KEY_CNT = 8'h5A;

	localparam int WDT_OVF_PULSE_DEF = 128;

	// Timer channel bases
	localparam ibus_addr_t ITU0_BASE = 28'h5FFFF04;
	localparam ibus_addr_t ITU1_BASE = 28'h5FFFF0E;

	// Register offsets within a channel
	localparam ibus_addr_t ITU_TCR_OFS  = 28'd0;
	localparam ibus_addr_t ITU_TIER_OFS = 28'd1;
	localparam ibus_addr_t ITU_TSR_OFS  = 28'd2;
	localparam ibus_addr_t ITU_TCNT_OFS = 28'd4;
	localparam ibus_addr_t ITU_GRA_OFS  = 28'd6;

endpackage

`default_nettype wire
